// ==== logic/abacus_pkg.sv ====
package abacus_pkg;

	// Bus and counter width
	localparam int unsigned data_w = 32;

	localparam int unsigned num_instr_classes = 11;
	localparam int unsigned num_stall_events = 9;

	// Instruction classes first, stall events after them
	localparam int unsigned num_counters = num_instr_classes + num_stall_events;

	typedef logic [4:0] cnt_idx_t;

	// Values double as counter indices 0 to 10
	typedef enum logic [3:0]
	{
		class_load,
		class_store,
		class_add,
		class_sub,
		class_logical,
		class_shift,
		class_compare,
		class_branch,
		class_jump,
		class_system,
		class_atomic,
		class_none
	} instr_class_e;

	// One instruction word, seen as R-type or I-type
	typedef union packed
	{
		struct packed
		{
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed
		{
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
	} rv_instr_u;

	// RV32 major opcodes
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_op = 7'b0110011;
	localparam logic [6:0] op_op_imm = 7'b0010011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_system = 7'b1110011;
	localparam logic [6:0] op_amo = 7'b0101111;

	// Register map, relative to the block base address
	localparam logic [31:0] instr_enable_off = 32'h0000_0004;
	localparam logic [31:0] stall_enable_off = 32'h0000_000C;
	localparam logic [31:0] instr_cnt_off = 32'h0000_0100;
	localparam logic [31:0] stall_cnt_off = 32'h0000_0300;

endpackage

// ==== logic/prof_event_if.sv ====
`timescale 1ns/1ps

// Payload is the raw word after capture and the decoded class after classify
interface prof_event_if import abacus_pkg::*;
#(
	parameter type payload_t = rv_instr_u
);

	logic instr_valid;
	payload_t payload;
	logic stall_valid;
	logic [num_stall_events-1:0] stall_vec;

	modport source
	(
		output instr_valid,
		output payload,
		output stall_valid,
		output stall_vec
	);

	modport sink
	(
		input instr_valid,
		input payload,
		input stall_valid,
		input stall_vec
	);

endinterface

// ==== logic/issue_capture.sv ====
`timescale 1ns/1ps

module issue_capture import abacus_pkg::*;
(
	input logic S_AXI_ACLK,
	input logic rst,
	input logic [data_w-1:0] instr_i,
	input logic instr_issued_i,
	input logic [num_stall_events-1:0] stall_i,
	prof_event_if.source ev_o
);

	logic any_stall;

	assign any_stall = |stall_i;

	// One strobe per cycle, no hold-off towards the core
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			ev_o.instr_valid <= 1'b0;
			ev_o.stall_valid <= 1'b0;
		end
		else
		begin
			ev_o.instr_valid <= instr_issued_i;
			ev_o.stall_valid <= any_stall;
		end
	end

	// Word and vector only load when they carry an event
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (instr_issued_i)
			ev_o.payload <= instr_i;
		if (any_stall)
			ev_o.stall_vec <= stall_i;
	end

endmodule

// ==== logic/instr_classifier.sv ====
`timescale 1ns/1ps

module instr_classifier import abacus_pkg::*;
(
	input logic S_AXI_ACLK,
	input logic rst,
	prof_event_if.sink ev_i,
	prof_event_if.source ev_o
);

	rv_instr_u word;
	instr_class_e class_d;

	// Shared by OP and OP-IMM where sub_sel only matters for OP
	function automatic instr_class_e alu_class(input logic [2:0] funct3, input logic sub_sel);
		case (funct3)
			3'b000: alu_class = sub_sel ? class_sub : class_add;
			3'b001, 3'b101: alu_class = class_shift;
			3'b010, 3'b011: alu_class = class_compare;
			default: alu_class = class_logical;
		endcase
	endfunction

	assign word = ev_i.payload;

	always_comb
	begin
		case (word.i.opcode)
			op_load: class_d = class_load;
			op_store: class_d = class_store;
			op_op: class_d = alu_class(word.r.funct3, word.r.funct7[5]);
			// Upper bits here are immediate, never a sub selector
			op_op_imm: class_d = alu_class(word.i.funct3, 1'b0);
			op_branch: class_d = class_branch;
			op_jal, op_jalr: class_d = class_jump;
			op_system: class_d = class_system;
			op_amo: class_d = class_atomic;
			default: class_d = class_none;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			ev_o.instr_valid <= 1'b0;
			ev_o.stall_valid <= 1'b0;
		end
		else
		begin
			ev_o.instr_valid <= ev_i.instr_valid;
			ev_o.stall_valid <= ev_i.stall_valid;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ev_i.instr_valid)
			ev_o.payload <= class_d;
		if (ev_i.stall_valid)
			ev_o.stall_vec <= ev_i.stall_vec;
	end

	// An unknown word would silently fall into class_none
	a_word_known: assert property (@(posedge S_AXI_ACLK) disable iff (rst)
		ev_i.instr_valid |-> !$isunknown(word));

endmodule

// ==== logic/counter_bank.sv ====
`timescale 1ns/1ps

module counter_bank import abacus_pkg::*;
(
	input logic S_AXI_ACLK,
	input logic rst,
	prof_event_if.sink ev_i,
	input logic instr_en_i,
	input logic stall_en_i,
	input cnt_idx_t rd_idx_i,
	output logic [data_w-1:0] rd_data_o
);

	logic [data_w-1:0] cnt_q [num_counters];
	logic instr_hit;
	logic stall_hit;

	// class_none and anything past it is not counted
	assign instr_hit = instr_en_i && ev_i.instr_valid
		&& (int'(ev_i.payload) < num_instr_classes);
	assign stall_hit = stall_en_i && ev_i.stall_valid;

	// Counters wrap silently on overflow
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			for (int k = 0; k < num_counters; k++)
				cnt_q[k] <= '0;
		end
		else
		begin
			if (instr_hit)
				cnt_q[ev_i.payload] <= cnt_q[ev_i.payload] + 1'b1;
			// Several stall lines can fire together
			for (int j = 0; j < num_stall_events; j++)
			begin
				if (stall_hit && ev_i.stall_vec[j])
					cnt_q[num_instr_classes + j] <= cnt_q[num_instr_classes + j] + 1'b1;
			end
		end
	end

	always_comb
	begin
		rd_data_o = '0;
		if (rd_idx_i < cnt_idx_t'(num_counters))
			rd_data_o = cnt_q[rd_idx_i];
	end

	// Register decode parks the index at num_counters when no counter is addressed
	a_idx_in_range: assert property (@(posedge S_AXI_ACLK) disable iff (rst)
		rd_idx_i <= cnt_idx_t'(num_counters));

endmodule

// ==== logic/reg_access.sv ====
`timescale 1ns/1ps

module reg_access import abacus_pkg::*;
#(
	parameter logic [31:0] abacus_base_addr = 32'hF003_0000
)
(
	input logic S_AXI_ACLK,
	input logic rst,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [31:0] wb_adr_i,
	input logic [data_w-1:0] wb_dat_i,
	input logic [data_w-1:0] rd_data_i,
	output logic [data_w-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic instr_en_o,
	output logic stall_en_o,
	output cnt_idx_t rd_idx_o
);

	logic req;
	logic wr;
	logic [31:0] rel;
	logic [31:0] instr_cnt_rel;
	logic [31:0] stall_cnt_rel;
	logic hit_instr_en;
	logic hit_stall_en;
	logic hit_instr_cnt;
	logic hit_stall_cnt;
	logic instr_en_q;
	logic stall_en_q;
	logic [data_w-1:0] rd_word;

	// New request only while no ack is pending
	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign wr = req && wb_we_i;

	assign rel = wb_adr_i - abacus_base_addr;
	assign instr_cnt_rel = rel - instr_cnt_off;
	assign stall_cnt_rel = rel - stall_cnt_off;

	assign hit_instr_en = (rel == instr_enable_off);
	assign hit_stall_en = (rel == stall_enable_off);
	// Below-range addresses wrap to large values and miss
	assign hit_instr_cnt = (instr_cnt_rel < 32'(4 * num_instr_classes)) && (rel[1:0] == 2'b00);
	assign hit_stall_cnt = (stall_cnt_rel < 32'(4 * num_stall_events)) && (rel[1:0] == 2'b00);

	always_comb
	begin
		rd_idx_o = cnt_idx_t'(num_counters);
		if (hit_instr_cnt)
			rd_idx_o = cnt_idx_t'(instr_cnt_rel >> 2);
		else if (hit_stall_cnt)
			rd_idx_o = cnt_idx_t'(num_instr_classes) + cnt_idx_t'(stall_cnt_rel >> 2);
	end

	always_comb
	begin
		rd_word = '0;
		if (hit_instr_en)
			rd_word = data_w'(instr_en_q);
		else if (hit_stall_en)
			rd_word = data_w'(stall_en_q);
		else if (hit_instr_cnt || hit_stall_cnt)
			rd_word = rd_data_i;
	end

	// Written enable already gates the increment on the write edge
	assign instr_en_o = (wr && hit_instr_en) ? wb_dat_i[0] : instr_en_q;
	assign stall_en_o = (wr && hit_stall_en) ? wb_dat_i[0] : stall_en_q;

	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			wb_ack_o <= 1'b0;
			wb_dat_o <= '0;
			instr_en_q <= 1'b0;
			stall_en_q <= 1'b0;
		end
		else
		begin
			wb_ack_o <= req;
			wb_dat_o <= (req && !wb_we_i) ? rd_word : '0;
			instr_en_q <= instr_en_o;
			stall_en_q <= stall_en_o;
		end
	end

	// Address decode and direction need known bus values on an accepted request
	a_req_known: assert property (@(posedge S_AXI_ACLK) disable iff (rst)
		req |-> !$isunknown({wb_we_i, wb_adr_i}));

endmodule

// ==== logic/abacus_top.sv ====
`timescale 1ns/1ps

module abacus_top import abacus_pkg::*;
#(
	parameter logic [31:0] abacus_base_addr = 32'hF003_0000
)
(
	input logic S_AXI_ACLK,
	input logic rst,
	input logic [31:0] instr_i,
	input logic instr_issued_i,
	input logic [8:0] stall_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [31:0] wb_adr_i,
	input logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o
);

	cnt_idx_t rd_idx;
	logic [data_w-1:0] rd_data;
	logic instr_en;
	logic stall_en;

	// Raw word between capture and classify, decoded class after that
	prof_event_if #(.payload_t(rv_instr_u)) cap_ev ();
	prof_event_if #(.payload_t(instr_class_e)) cls_ev ();

	issue_capture u_capture
	(
		.S_AXI_ACLK(S_AXI_ACLK),
		.rst(rst),
		.instr_i(instr_i),
		.instr_issued_i(instr_issued_i),
		.stall_i(stall_i),
		.ev_o(cap_ev)
	);

	instr_classifier u_classifier
	(
		.S_AXI_ACLK(S_AXI_ACLK),
		.rst(rst),
		.ev_i(cap_ev),
		.ev_o(cls_ev)
	);

	counter_bank u_counters
	(
		.S_AXI_ACLK(S_AXI_ACLK),
		.rst(rst),
		.ev_i(cls_ev),
		.instr_en_i(instr_en),
		.stall_en_i(stall_en),
		.rd_idx_i(rd_idx),
		.rd_data_o(rd_data)
	);

	reg_access #(.abacus_base_addr(abacus_base_addr)) u_regs
	(
		.S_AXI_ACLK(S_AXI_ACLK),
		.rst(rst),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.rd_data_i(rd_data),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.instr_en_o(instr_en),
		.stall_en_o(stall_en),
		.rd_idx_o(rd_idx)
	);

endmodule

// ==== dv/abacus_tb.sv ====
`timescale 1ns/1ps

module abacus_tb;

	localparam logic [31:0] base_addr = 32'hF003_0000;
	localparam int ack_wait_max = 4;
	localparam int read_settle = 4;

	logic S_AXI_ACLK;
	logic rst;
	logic [31:0] instr_i;
	logic instr_issued_i;
	logic [8:0] stall_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	logic [31:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic wb_ack_o;

	// Test records, one entry per data line
	string names[$];
	string kinds[$];
	logic [31:0] args[$];
	logic [31:0] vals[$];

	int cycle_count = 0;
	int cycle_limit = 100;
	int pass_count = 0;
	int fail_count = 0;

	abacus_top #(.abacus_base_addr(base_addr)) dut
	(
		.S_AXI_ACLK(S_AXI_ACLK),
		.rst(rst),
		.instr_i(instr_i),
		.instr_issued_i(instr_issued_i),
		.stall_i(stall_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Watchdog, limit is set once the records are loaded
	always @(posedge S_AXI_ACLK)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Skips blank lines and lines starting with #
	task automatic load_records(output bit loaded);
		int fd;
		int n;
		string line;
		string name;
		string kind;
		logic [31:0] a;
		logic [31:0] d;
		loaded = 1'b0;
		fd = $fopen("dv/abacus_tests.txt", "r");
		if (fd != 0)
		begin
			while ($fgets(line, fd))
			begin
				if (line.len() > 0 && line.getc(0) != "#")
				begin
					n = $sscanf(line, "%s %s %h %h", name, kind, a, d);
					if (n == 4)
					begin
						names.push_back(name);
						kinds.push_back(kind);
						args.push_back(a);
						vals.push_back(d);
					end
				end
			end
			$fclose(fd);
			loaded = (names.size() > 0);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge S_AXI_ACLK);
		#1;
	endtask

	// One Wishbone request, held until the ack or the wait limit
	task automatic wb_transfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
		output logic [31:0] rdata, output bit got_ack);
		int waited;
		waited = 0;
		got_ack = 1'b0;
		rdata = '0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = base_addr + adr;
		wb_dat_i = dat;
		while (!got_ack && waited < ack_wait_max)
		begin
			@(posedge S_AXI_ACLK);
			#1;
			waited++;
			if (wb_ack_o)
			begin
				got_ack = 1'b1;
				rdata = wb_dat_o;
			end
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	// Word is on the bus for one cycle, issued or not
	task automatic issue_word(input logic [31:0] word, input logic issued);
		instr_i = word;
		instr_issued_i = issued;
		idle_cycles(1);
		instr_issued_i = 1'b0;
	endtask

	task automatic present_stall(input logic [8:0] vec, input int cycles);
		stall_i = vec;
		idle_cycles(cycles);
		stall_i = '0;
	endtask

	task automatic run_record(input int i);
		logic [31:0] rdata;
		bit got_ack;
		bit test_ok;
		test_ok = 1'b1;
		case (kinds[i])
			"W":
			begin
				wb_transfer(1'b1, args[i], vals[i], rdata, got_ack);
				assert (got_ack)
				else
				begin
					$display("%s: write got no acknowledge from the register port", names[i]);
					test_ok = 1'b0;
				end
			end
			"R":
			begin
				// Let every earlier event drain through the three stages
				idle_cycles(read_settle);
				wb_transfer(1'b0, args[i], 32'h0, rdata, got_ack);
				assert (got_ack)
				else
				begin
					$display("%s: read got no acknowledge from the register port", names[i]);
					test_ok = 1'b0;
				end
				if (got_ack)
				begin
					assert (rdata == vals[i])
					else
					begin
						$display("ERROR %s expected %h actual %h", names[i], vals[i], rdata);
						test_ok = 1'b0;
					end
				end
			end
			"I": issue_word(args[i], vals[i][0]);
			"S": present_stall(args[i][8:0], int'(vals[i]));
			"N": idle_cycles(int'(args[i]));
			default:
			begin
				$display("%s: unknown record kind %s", names[i], kinds[i]);
				test_ok = 1'b0;
			end
		endcase
		if (test_ok)
		begin
			pass_count++;
			$display("test %0d %s: ok", i, names[i]);
		end
		else
		begin
			fail_count++;
			$display("test %0d %s: failed", i, names[i]);
		end
	endtask

	initial
	begin
		bit loaded;
		rst = 1'b1;
		instr_i = '0;
		instr_issued_i = 1'b0;
		stall_i = '0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		load_records(loaded);
		cycle_limit = names.size() * 8 + 100;
		if (!loaded)
		begin
			$display("Could not read any records from dv/abacus_tests.txt");
			fail_count++;
		end
		else
		begin
			repeat (16) @(posedge S_AXI_ACLK);
			#1;
			rst = 1'b0;
			for (int i = 0; i < names.size(); i++)
				run_record(i);
		end
		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== dv/abacus_tests.txt ====
# name kind arg value, hex fields; W/R arg is the offset from base, value is data or expected
# I arg is the word, value 1 issues it; S arg is the vector, value the cycles; N arg is cycles
rst_instr_en R 00000004 00000000
rst_stall_en R 0000000C 00000000
rst_cnt_add R 00000108 00000000
rst_unmapped R 00000050 00000000
dis_add I 00000033 00000001
dis_check R 00000108 00000000
en_instr W 00000004 00000001
add_op I 00B50533 00000001
sub_op I 40B50533 00000001
addi_neg I FFF50513 00000001
lw I 0005A503 00000001
gap N 00000002 00000000
xor_op I 00B54533 00000001
lui_none I 00000037 00000001
jal I 0000006F 00000001
not_issued I 00B50533 00000000
chk_add R 00000108 00000002
chk_sub R 0000010C 00000001
chk_load R 00000100 00000001
chk_logical R 00000110 00000001
chk_jump R 00000120 00000001
en_stall W 0000000C 00000001
stall_multi S 00000025 00000003
chk_stall0 R 00000300 00000003
chk_stall5 R 00000314 00000003
chk_stall1 R 00000304 00000000
wr_cnt W 00000300 00000055
dis_stall W 0000000C 00000000
stall_off S 00000001 00000002
chk_stall_hold R 00000300 00000003
chk_en_off R 0000000C 00000000

// ==== src.f ====
logic/abacus_pkg.sv
logic/prof_event_if.sv
logic/issue_capture.sv
logic/instr_classifier.sv
logic/counter_bank.sv
logic/reg_access.sv
logic/abacus_top.sv
dv/abacus_tb.sv
